// ==== source/isaPkg.sv ====
package isaPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;

    // Major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcodeE;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL
    } aluOpE;

    // funct3 codes for OP and OP_IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD = 3'b000; // Also SUB
    localparam logic [FUNCT3_W-1:0] F3_SLL = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_XOR = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR  = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND = 3'b111;

    // Memory and branch funct3
    localparam logic [FUNCT3_W-1:0] F3_WORD = 3'b010; // LW and SW
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;

    // Instruction bit 30, picks SUB over ADD and SRA over SRL
    localparam logic F7_ALT = 1'b1;

endpackage

// ==== source/cpuPkg.sv ====
package cpuPkg;
    import isaPkg::*;

    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_DEPTH  = 16;
    localparam int DMEM_ADDR_W = 4; // From address bits 5:2

    // Decoded control word
    typedef struct packed {
        aluOpE                 aluOp;
        logic                  aluSrcImm;
        logic                  regWrite;
        logic                  memWrite;
        logic                  memToReg;
        logic                  branch;
        logic                  branchNe;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm; // Sign-extended
    } ctrlT;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } regWriteT;

    typedef struct packed {
        logic                   we;
        logic [DMEM_ADDR_W-1:0] addr; // Word index
        logic [XLEN-1:0]        data;
    } memWriteT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        regWriteT        regWr;
        memWriteT        memWr;
        logic [XLEN-1:0] nextPc;
    } retireT;

endpackage

// ==== source/instFetch.sv ====
`timescale 1ns/1ps

module instFetch
    import isaPkg::*, cpuPkg::*;
(
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   loadEn,
    input  logic [IMEM_ADDR_W-1:0] loadAddr,
    input  logic [XLEN-1:0]        loadData,
    input  logic                   branchTaken,
    input  logic [XLEN-1:0]        branchTarget,
    output logic [XLEN-1:0]        pc,
    output logic [XLEN-1:0]        inst,
    output logic [XLEN-1:0]        nextPc
);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pcPlus4;

    // Program load port
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Word index from the byte PC
    assign inst = imem[pc[IMEM_ADDR_W+1:2]];

    assign pcPlus4 = pc + 32'd4;
    assign nextPc  = branchTaken ? branchTarget : pcPlus4;

    // Held at zero while the program is loaded
    always_ff @(posedge CLK) begin
        if (RST || loadEn) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== source/instDecode.sv ====
`timescale 1ns/1ps

module instDecode
    import isaPkg::*, cpuPkg::*;
(
    input  logic [XLEN-1:0] inst,
    output ctrlT            ctrl
);

    logic [FUNCT3_W-1:0] funct3;
    logic                altBit;
    logic [6:0]          funct7;
    logic [XLEN-1:0]     immI;
    logic [XLEN-1:0]     immS;
    logic [XLEN-1:0]     immB;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign altBit = inst[30];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        // No-op unless a case below recognizes the word
        ctrl           = '0;
        ctrl.aluOp     = ADD;
        ctrl.rs1       = inst[19:15];
        ctrl.rs2       = inst[24:20];
        ctrl.rd        = inst[11:7];

        case (opcodeE'(inst[6:0]))
            OP: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && funct3 == F3_ADD)) begin
                    ctrl.regWrite = 1'b1;
                    case (funct3)
                        F3_ADD:  ctrl.aluOp = (altBit == F7_ALT) ? SUB : ADD;
                        F3_SLL:  ctrl.aluOp = SLL;
                        F3_SLT:  ctrl.aluOp = SLT;
                        F3_XOR:  ctrl.aluOp = XOR;
                        F3_SRL:  ctrl.aluOp = SRL; // Alt form would be SRA and is excluded above
                        F3_OR:   ctrl.aluOp = OR;
                        F3_AND:  ctrl.aluOp = AND;
                        default: ctrl.regWrite = 1'b0; // SLTU
                    endcase
                end
            end
            OP_IMM: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immI;
                ctrl.regWrite  = 1'b1;
                case (funct3)
                    F3_ADD:  ctrl.aluOp = ADD;
                    F3_SLT:  ctrl.aluOp = SLT;
                    F3_XOR:  ctrl.aluOp = XOR;
                    F3_OR:   ctrl.aluOp = OR;
                    F3_AND:  ctrl.aluOp = AND;
                    default: ctrl.regWrite = 1'b0; // Immediate shifts not supported
                endcase
            end
            LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.imm       = immI;
                    ctrl.regWrite  = 1'b1;
                    ctrl.memToReg  = 1'b1;
                end
            end
            STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.imm       = immS;
                    ctrl.memWrite  = 1'b1;
                end
            end
            BRANCH: begin
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    ctrl.imm      = immB;
                    ctrl.branch   = 1'b1;
                    ctrl.branchNe = (funct3 == F3_BNE);
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import isaPkg::*;
(
    input  logic                  CLK,
    input  logic                  RST,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       wd,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2
);

    logic [XLEN-1:0] regs [32];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1]; // Asynchronous reads
    assign rd2 = regs[rs2];

endmodule

// ==== source/execUnit.sv ====
`timescale 1ns/1ps

module execUnit
    import isaPkg::*, cpuPkg::*;
(
    input  ctrlT            ctrl,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rd1,
    input  logic [XLEN-1:0] rd2,
    output logic [XLEN-1:0] aluResult,
    output logic            branchTaken,
    output logic [XLEN-1:0] branchTarget
);

    logic [XLEN-1:0] opB;
    logic [4:0]      shamt;
    logic            operandsEq;

    assign opB   = ctrl.aluSrcImm ? ctrl.imm : rd2;
    assign shamt = opB[4:0];

    always_comb begin
        case (ctrl.aluOp)
            ADD:     aluResult = rd1 + opB;
            SUB:     aluResult = rd1 - opB;
            AND:     aluResult = rd1 & opB;
            OR:      aluResult = rd1 | opB;
            XOR:     aluResult = rd1 ^ opB;
            SLT:     aluResult = {31'd0, $signed(rd1) < $signed(opB)};
            SLL:     aluResult = rd1 << shamt;
            SRL:     aluResult = rd1 >> shamt;
            default: aluResult = '0;
        endcase
    end

    // Branches compare the two registers, not the ALU operand
    assign operandsEq   = (rd1 == rd2);
    assign branchTaken  = ctrl.branch && (ctrl.branchNe ? !operandsEq : operandsEq);
    assign branchTarget = pc + ctrl.imm;

endmodule

// ==== source/dataMem.sv ====
`timescale 1ns/1ps

module dataMem
    import isaPkg::*, cpuPkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            we,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wd,
    output logic [XLEN-1:0] rdata
);

    logic [XLEN-1:0]        mem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] wordIdx;

    assign wordIdx = addr[DMEM_ADDR_W+1:2]; // Upper bits wrap

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    assign rdata = mem[wordIdx];

endmodule

// ==== source/singleCpu.sv ====
`timescale 1ns/1ps

module singleCpu
    import isaPkg::*, cpuPkg::*;
(
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   loadEn,
    input  logic [IMEM_ADDR_W-1:0] loadAddr,
    input  logic [XLEN-1:0]        loadData,
    output logic                   retireValid,
    output retireT                 retire
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] nextPc;
    ctrlT            ctrl;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] aluResult;
    logic            branchTaken;
    logic [XLEN-1:0] branchTarget;
    logic [XLEN-1:0] memRdata;
    logic            run;
    regWriteT        regWr;
    memWriteT        memWr;

    // Machine only retires outside reset and program load
    assign run = !(RST || loadEn);

    instFetch instFetch_i (
        .CLK, .RST, .loadEn, .loadAddr, .loadData,
        .branchTaken, .branchTarget,
        .pc, .inst, .nextPc
    );

    instDecode instDecode_i (.inst, .ctrl);

    regFile regFile_i (
        .CLK, .RST,
        .rs1(ctrl.rs1), .rs2(ctrl.rs2),
        .we(regWr.we), .rd(regWr.rd), .wd(regWr.data),
        .rd1, .rd2
    );

    execUnit execUnit_i (.ctrl, .pc, .rd1, .rd2, .aluResult, .branchTaken, .branchTarget);

    dataMem dataMem_i (
        .CLK, .RST,
        .we(memWr.we), .addr(aluResult), .wd(rd2),
        .rdata(memRdata)
    );

    // Write-back mux, x0 writes dropped here so the record shows we low
    assign regWr.we   = run && ctrl.regWrite && (ctrl.rd != '0);
    assign regWr.rd   = ctrl.rd;
    assign regWr.data = ctrl.memToReg ? memRdata : aluResult;

    assign memWr.we   = run && ctrl.memWrite;
    assign memWr.addr = aluResult[DMEM_ADDR_W+1:2];
    assign memWr.data = rd2;

    assign retireValid   = run;
    assign retire.pc     = pc;
    assign retire.inst   = inst;
    assign retire.regWr  = regWr;
    assign retire.memWr  = memWr;
    assign retire.nextPc = nextPc;

endmodule

// ==== dv/singleCpu_props.sv ====
`timescale 1ns/1ps

module singleCpuProps
    import isaPkg::*, cpuPkg::*;
(
    input logic   CLK,
    input logic   RST,
    input logic   loadEn,
    input logic   retireValid,
    input retireT retire
);

    // Machine restarts from address 0 after reset or a program load
    assert property (@(posedge CLK) (retireValid && $past(RST || loadEn)) |-> (retire.pc == '0))
        else $error("First retirement after reset or program load not at PC 0");

    // Destination taken from the rd field of the instruction
    assert property (@(posedge CLK) retire.regWr.we |->
                     (retire.regWr.rd == retire.inst[11:7]) && (retire.inst[11:7] != '0))
        else $error("Register write retired with a wrong or x0 destination");

    // Stores and register writes are exclusive in this subset
    assert property (@(posedge CLK) !(retire.regWr.we && retire.memWr.we))
        else $error("Register write and memory write in the same retirement");

endmodule

bind singleCpu singleCpuProps singleCpuProps_i (.CLK, .RST, .loadEn, .retireValid, .retire);

// ==== dv/singleCpuTb.sv ====
`timescale 1ns/1ps

module singleCpuTb
    import isaPkg::*, cpuPkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int SAMPLE_DELAY    = CLK_PERIOD / 4; // Settled well before the next edge
    localparam int RESET_CYCLES    = 2;
    localparam int RUN_CYCLES      = 80;
    localparam int PROG_WORDS      = 48;
    localparam int NUM_PROGS       = 4;
    localparam int CYCLES_PER_PROG = IMEM_DEPTH + RUN_CYCLES + RESET_CYCLES;
    localparam int WATCHDOG_NS     =
        2 * (NUM_PROGS * CYCLES_PER_PROG + RESET_CYCLES + 1) * CLK_PERIOD;

    logic                   CLK;
    logic                   RST;
    logic                   loadEn;
    logic [IMEM_ADDR_W-1:0] loadAddr;
    logic [XLEN-1:0]        loadData;
    logic                   retireValid;
    retireT                 retire;

    logic [31:0]     lfsrState;
    logic [XLEN-1:0] progMem [IMEM_DEPTH];
    logic [XLEN-1:0] modelRegs [32];
    logic [XLEN-1:0] modelMem [DMEM_DEPTH];
    logic [XLEN-1:0] modelPc;

    singleCpu singleCpu_i (.CLK, .RST, .loadEn, .loadAddr, .loadData, .retireValid, .retire);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    task automatic stopWithFailure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic reportMismatch(input string msg);
        stopWithFailure($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    // Galois LFSR stepped once per random bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hB4BC_D35C) : (lfsrState >> 1);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [2:0] f3Of(input aluOpE op);
        case (op)
            SLL:     return F3_SLL;
            SLT:     return F3_SLT;
            XOR:     return F3_XOR;
            SRL:     return F3_SRL;
            OR:      return F3_OR;
            AND:     return F3_AND;
            default: return F3_ADD; // ADD and SUB
        endcase
    endfunction

    function automatic logic [XLEN-1:0] genInst();
        logic [31:0] r;
        logic [3:0]  kind;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [12:0] off;
        aluOpE       op;
        r = randBits(4);
        kind = r[3:0];
        r = randBits(9);
        rd = {2'b00, r[2:0]}; // x0..x7 keeps operands dependent
        rs1 = {2'b00, r[5:3]};
        rs2 = {2'b00, r[8:6]};
        r = randBits(12);
        imm = r[11:0];
        r = randBits(3);
        op = aluOpE'(r[2:0]);
        if (kind < 4'd5) begin
            return {(op == SUB) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3Of(op), rd, OP};
        end else if (kind < 4'd8) begin
            // No immediate form of SUB or the shifts here
            op = (op == SUB) ? ADD : (op == SLL) ? SLT : (op == SRL) ? XOR : op;
            return {imm, rs1, f3Of(op), rd, OP_IMM};
        end else if (kind < 4'd10) begin
            return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
        end else if (kind < 4'd12) begin
            return {imm, rs1, F3_WORD, rd, LOAD};
        end else if (kind < 4'd14) begin
            r = randBits(2);
            off = {8'd0, 3'(r[1:0]) + 3'd1, 2'b00}; // Forward only by 4 to 16 bytes
            return {off[12], off[10:5], rs2, rs1, kind[0] ? F3_BNE : F3_BEQ,
                    off[4:1], off[11], BRANCH};
        end else if (kind == 4'd14) begin
            return '0;
        end
        r = randBits(27);
        case (r[26:25]) // LUI, JAL, SRA, SLLI
            2'd0:    return {r[24:0], 7'b0110111};
            2'd1:    return {r[24:0], 7'b1101111};
            2'd2:    return {7'b0100000, r[24:15], F3_SRL, r[14:10], OP};
            default: return {7'b0000000, r[24:15], F3_SLL, r[14:10], OP_IMM};
        endcase
    endfunction

    function automatic logic [XLEN-1:0] aluModel(input aluOpE op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        case (op)
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            default: return a + b;
        endcase
    endfunction

    task automatic checkRegWrite(input regWriteT got, input regWriteT exp);
        if (got.we !== exp.we) begin
            reportMismatch($sformatf("register write enable %0b, expected %0b", got.we, exp.we));
        end else if (exp.we && (got.rd !== exp.rd || got.data !== exp.data)) begin
            reportMismatch($sformatf("register write x%0d=%h, expected x%0d=%h",
                                     got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic checkMemWrite(input memWriteT got, input memWriteT exp);
        if (got.we !== exp.we) begin
            reportMismatch($sformatf("memory write enable %0b, expected %0b", got.we, exp.we));
        end else if (exp.we && (got.addr !== exp.addr || got.data !== exp.data)) begin
            reportMismatch($sformatf("memory write [%0d]=%h, expected [%0d]=%h",
                                     got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    task automatic checkPc(input logic [XLEN-1:0] gotPc, input logic [XLEN-1:0] expPc,
                           input logic [XLEN-1:0] gotNext, input logic [XLEN-1:0] expNext);
        if (gotPc !== expPc || gotNext !== expNext) begin
            reportMismatch($sformatf("pc %h next %h, expected pc %h next %h",
                                     gotPc, gotNext, expPc, expNext));
        end
    endtask

    task automatic checkInst(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("retired instruction %h, expected %h", got, exp));
        end
    endtask

    task automatic checkIdle(input string phase);
        if (retireValid !== 1'b0) begin
            reportMismatch($sformatf("retireValid high during %s", phase));
        end
    endtask

    // Architectural step of one instruction and compare with the retire record
    task automatic stepModel(input retireT got);
        logic [XLEN-1:0] inst, a, b, immI, immS, immB, addr, nextPc;
        regWriteT        expReg;
        memWriteT        expMem;
        aluOpE           op;
        logic            valid;
        inst = progMem[modelPc[7:2]];
        a = modelRegs[inst[19:15]];
        b = modelRegs[inst[24:20]];
        immI = {{20{inst[31]}}, inst[31:20]};
        immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        expReg = '0;
        expMem = '0;
        expReg.rd = inst[11:7];
        nextPc = modelPc + 32'd4;
        op = ADD;
        valid = 1'b1;
        case (opcodeE'(inst[6:0]))
            OP: begin
                case ({inst[31:25], inst[14:12]})
                    {7'h00, F3_ADD}: op = ADD;
                    {7'h20, F3_ADD}: op = SUB;
                    {7'h00, F3_SLL}: op = SLL;
                    {7'h00, F3_SLT}: op = SLT;
                    {7'h00, F3_XOR}: op = XOR;
                    {7'h00, F3_SRL}: op = SRL;
                    {7'h00, F3_OR}:  op = OR;
                    {7'h00, F3_AND}: op = AND;
                    default:         valid = 1'b0;
                endcase
                expReg.we = valid;
                expReg.data = aluModel(op, a, b);
            end
            OP_IMM: begin
                case (inst[14:12])
                    F3_ADD:  op = ADD;
                    F3_SLT:  op = SLT;
                    F3_XOR:  op = XOR;
                    F3_OR:   op = OR;
                    F3_AND:  op = AND;
                    default: valid = 1'b0;
                endcase
                expReg.we = valid;
                expReg.data = aluModel(op, a, immI);
            end
            LOAD: begin
                addr = a + immI;
                expReg.we = (inst[14:12] == F3_WORD);
                expReg.data = modelMem[addr[5:2]];
            end
            STORE: begin
                addr = a + immS;
                expMem.we = (inst[14:12] == F3_WORD);
                expMem.addr = addr[5:2];
                expMem.data = b;
            end
            BRANCH: begin
                if ((inst[14:12] == F3_BEQ && a == b) || (inst[14:12] == F3_BNE && a != b)) begin
                    nextPc = modelPc + immB;
                end
            end
            default: ;
        endcase
        if (expReg.rd == '0) begin
            expReg.we = 1'b0; // x0 writes are dropped
        end
        checkPc(got.pc, modelPc, got.nextPc, nextPc);
        checkInst(got.inst, inst);
        checkRegWrite(got.regWr, expReg);
        checkMemWrite(got.memWr, expMem);
        if (expReg.we) begin
            modelRegs[expReg.rd] = expReg.data;
        end
        if (expMem.we) begin
            modelMem[expMem.addr] = expMem.data;
        end
        modelPc = nextPc;
    endtask

    task automatic applyReset();
        RST = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            #(SAMPLE_DELAY);
            checkIdle("reset");
            @(negedge CLK);
        end
        RST = 1'b0;
        modelPc = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            modelMem[i] = '0;
        end
    endtask

    task automatic loadProgram();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            if (i < PROG_WORDS) begin
                progMem[i] = genInst();
            end else begin
                progMem[i] = '0; // Tail reads back as no-ops
            end
        end
        loadEn = 1'b1;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            loadAddr = IMEM_ADDR_W'(i);
            loadData = progMem[i];
            #(SAMPLE_DELAY);
            checkIdle("program load");
            @(negedge CLK);
        end
        loadEn = 1'b0;
    endtask

    task automatic runProgram();
        repeat (RUN_CYCLES) begin
            #(SAMPLE_DELAY);
            if (retireValid !== 1'b1) begin
                reportMismatch("retireValid low while running");
            end
            stepModel(retire);
            @(negedge CLK);
        end
    endtask

    initial begin
        CLK = 1'b0;
        RST = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        lfsrState = 32'd82;
        applyReset();
        for (int p = 0; p < NUM_PROGS; p++) begin
            loadProgram();
            runProgram();
            applyReset();
        end
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog sized from the load and run lengths of all programs
    initial begin
        #(WATCHDOG_NS);
        stopWithFailure("Timeout: the test sequence did not complete in time");
    end

endmodule

// ==== flist.f ====
source/isaPkg.sv
source/cpuPkg.sv
source/instFetch.sv
source/instDecode.sv
source/regFile.sv
source/execUnit.sv
source/dataMem.sv
source/singleCpu.sv
dv/singleCpu_props.sv
dv/singleCpuTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module singleCpuTb -f flist.f -o simv \
    && ./obj_dir/simv \
    || { echo "Simulation build or run failed"; exit 1; }
